// File: Bender.yml
package:
  name: mandel

sources:
  - include_dirs:
      - design
    files:
      - design/mandel_pkg.sv
      - design/mandel_iterator.sv
      - design/palette_lut.sv
      - design/pixel_walker.sv
      - design/apb_regs.sv
      - design/mandel_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/mandel_assert.sv
      - verif/mandel_tb.sv

// File: design/apb_regs.sv
`timescale 1ns/1ps
`include "mandel_consts.svh"
`default_nettype none

module apb_regs (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    psel,
	input  wire                    penable,
	input  wire                    pwrite,
	input  mandel_pkg::apb_addr_t  paddr,
	input  mandel_pkg::word_t      pwdata,
	output mandel_pkg::word_t      prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  wire                    frame_done,
	output logic                   frame_start,
	output mandel_pkg::fixed_t     cr_start,
	output mandel_pkg::fixed_t     ci_start,
	output mandel_pkg::fixed_t     dx,
	output mandel_pkg::fixed_t     dy,
	output mandel_pkg::coord_t     cols,
	output mandel_pkg::coord_t     rows,
	output mandel_pkg::iter_t      max_iter
);

	logic access;
	logic wr_en;
	logic mapped;
	logic start_req;
	logic busy;
	logic done;
	mandel_pkg::word_t cycles;

	// Zero wait states, everything resolves in the access phase
	assign pready = 1'b1;
	assign access = psel & penable;
	assign wr_en  = access & pwrite;

	always_comb begin
		case (paddr)
			`REG_CTRL, `REG_STATUS, `REG_CR_START, `REG_CI_START,
			`REG_DX, `REG_DY, `REG_SIZE, `REG_MAX_ITER, `REG_CYCLES:
				mapped = 1'b1;
			default: mapped = 1'b0;
		endcase
	end

	// Config is frozen during a frame, only CTRL may be touched then
	assign pslverr = access & (~mapped | (pwrite & busy & (paddr != `REG_CTRL)));

	// Start only from idle, a repeated start mid-frame is dropped
	assign start_req = wr_en & (paddr == `REG_CTRL) & pwdata[0] & ~busy;

	//////////////////////////////
	// Frame control and timer
	//////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frame_start <= 1'b0;
			busy        <= 1'b0;
			done        <= 1'b0;
			cycles      <= '0;
		end else begin
			frame_start <= start_req;
			if (start_req) begin
				busy <= 1'b1;
				done <= 1'b0;
			end else if (frame_done) begin
				busy <= 1'b0;
				done <= 1'b1;  // Sticky until next start
			end
			// Counts every busy cycle, holds after the frame
			if (start_req)
				cycles <= '0;
			else if (busy)
				cycles <= cycles + 1'b1;
		end
	end

	//////////////////////////////
	// Config registers
	//////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cr_start <= '0;
			ci_start <= '0;
			dx       <= '0;
			dy       <= '0;
			cols     <= '0;
			rows     <= '0;
			max_iter <= `ITER_MAX_RESET;
		end else if (wr_en & ~busy) begin
			case (paddr)
				`REG_CR_START: cr_start <= pwdata[`FIXED_W-1:0];
				`REG_CI_START: ci_start <= pwdata[`FIXED_W-1:0];
				`REG_DX:       dx       <= pwdata[`FIXED_W-1:0];
				`REG_DY:       dy       <= pwdata[`FIXED_W-1:0];
				`REG_SIZE: begin
					cols <= pwdata[9:0];
					rows <= pwdata[25:16];
				end
				`REG_MAX_ITER: max_iter <= pwdata[`ITER_W-1:0];
				default: ;
			endcase
		end
	end

	// Read mux, fixed-point values come back sign extended
	always_comb begin
		prdata = '0;
		if (access & ~pwrite) begin
			case (paddr)
				`REG_STATUS:   prdata[1:0] = {done, busy};
				`REG_CR_START: prdata = mandel_pkg::word_t'(cr_start);
				`REG_CI_START: prdata = mandel_pkg::word_t'(ci_start);
				`REG_DX:       prdata = mandel_pkg::word_t'(dx);
				`REG_DY:       prdata = mandel_pkg::word_t'(dy);
				`REG_SIZE: begin
					prdata[9:0]   = cols;
					prdata[25:16] = rows;
				end
				`REG_MAX_ITER: prdata[`ITER_W-1:0] = max_iter;
				`REG_CYCLES:   prdata = cycles;
				default:       prdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/mandel_consts.svh
`ifndef MANDEL_CONSTS_SVH
`define MANDEL_CONSTS_SVH

`default_nettype none

// Datapath widths
`define FIXED_W     27
`define ITER_W      10
`define COORD_W     10
`define PIX_ADDR_W  19
`define COLOR_W     8
`define APB_ADDR_W  8
`define WORD_W      32

// Signed 4.23 format, escape at |z|^2 > 4.0
`define FRAC_BITS   23
`define ESCAPE_SQ   (4 << `FRAC_BITS)

`define ITER_MAX_RESET 999

// Palette thresholds, roughly 999 halved at each step
`define PAL_T1 500
`define PAL_T2 250
`define PAL_T3 125
`define PAL_T4 62
`define PAL_T5 31
`define PAL_T6 15
`define PAL_T7 7
`define PAL_T8 3

// APB register map, byte offsets
`define REG_CTRL      8'h00
`define REG_STATUS    8'h04
`define REG_CR_START  8'h08
`define REG_CI_START  8'h0C
`define REG_DX        8'h10
`define REG_DY        8'h14
`define REG_SIZE      8'h18
`define REG_MAX_ITER  8'h1C
`define REG_CYCLES    8'h20

`default_nettype wire

`endif

// File: design/mandel_iterator.sv
`timescale 1ns/1ps
`include "mandel_consts.svh"
`default_nettype none

module mandel_iterator (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 calc_start,
	input  mandel_pkg::fixed_t  cr,
	input  mandel_pkg::fixed_t  ci,
	input  mandel_pkg::iter_t   max_iter,
	output logic                calc_done,
	output mandel_pkg::iter_t   iter
);

	mandel_pkg::iter_state_t state;

	// Current z and its squares, squares already scaled back to 4.23
	mandel_pkg::fixed_t zr;
	mandel_pkg::fixed_t zi;
	mandel_pkg::fixed_t zr_sq;
	mandel_pkg::fixed_t zi_sq;
	mandel_pkg::iter_t  count;
	mandel_pkg::iter_t  count_next;

	// Full width products
	logic signed [2*`FIXED_W-1:0] prod_ri;
	logic signed [2*`FIXED_W-1:0] prod_rr;
	logic signed [2*`FIXED_W-1:0] prod_ii;
	logic signed [2*`FIXED_W-1:0] mag_sq;

	mandel_pkg::fixed_t zri;
	mandel_pkg::fixed_t zr_next;
	mandel_pkg::fixed_t zi_next;
	logic escaped;
	logic finish;

	//////////////////////////////
	// One iteration step
	//////////////////////////////
	always_comb begin
		// zr*zi scaled back to 4.23
		prod_ri = zr * zi;
		zri     = mandel_pkg::fixed_t'(prod_ri >>> `FRAC_BITS);

		// z' = z^2 + c
		zr_next = zr_sq - zi_sq + cr;
		zi_next = (zri <<< 1) + ci;

		// Squares of the new z for the next step and the escape test
		prod_rr = zr_next * zr_next;
		prod_ii = zi_next * zi_next;

		// Magnitude kept wide so a large escaped z cannot wrap below the limit
		mag_sq  = (prod_rr >>> `FRAC_BITS) + (prod_ii >>> `FRAC_BITS);
		escaped = mag_sq > `ESCAPE_SQ;

		count_next = count + 1'b1;
		finish     = escaped || (count_next >= max_iter);
	end

	//////////////////////////////
	// FSM and step counter
	//////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= mandel_pkg::ITER_IDLE;
			count     <= '0;
			calc_done <= 1'b0;
		end else begin
			calc_done <= 1'b0;
			case (state)
				mandel_pkg::ITER_IDLE: begin
					if (calc_start) begin
						count <= '0;
						state <= mandel_pkg::ITER_CALC;
					end
				end
				mandel_pkg::ITER_CALC: begin
					// Escaping step still counts
					count <= count_next;
					if (finish)
						state <= mandel_pkg::ITER_DONE;
				end
				mandel_pkg::ITER_DONE: begin
					calc_done <= 1'b1;
					state     <= mandel_pkg::ITER_IDLE;
				end
				default: state <= mandel_pkg::ITER_IDLE;
			endcase
		end
	end

	// z registers, loaded at start and stepped in CALC
	always_ff @(posedge clk) begin
		if (state == mandel_pkg::ITER_IDLE && calc_start) begin
			zr    <= '0;
			zi    <= '0;
			zr_sq <= '0;
			zi_sq <= '0;
		end else if (state == mandel_pkg::ITER_CALC) begin
			zr    <= zr_next;
			zi    <= zi_next;
			zr_sq <= mandel_pkg::fixed_t'(prod_rr >>> `FRAC_BITS);
			zi_sq <= mandel_pkg::fixed_t'(prod_ii >>> `FRAC_BITS);
		end
		// Result valid together with calc_done
		// CALC always counts at least one step
		if (state == mandel_pkg::ITER_DONE)
			iter <= count;
	end

endmodule

`default_nettype wire

// File: design/mandel_pkg.sv
`include "mandel_consts.svh"
`default_nettype none

package mandel_pkg;

	// Complex coordinate component, 1 sign + 3 integer + 23 fraction bits
	typedef logic signed [`FIXED_W-1:0] fixed_t;

	// Escape-time count
	typedef logic [`ITER_W-1:0] iter_t;

	// Pixel column or row index
	typedef logic [`COORD_W-1:0] coord_t;

	// Linear pixel address, enough for 640x480
	typedef logic [`PIX_ADDR_W-1:0] pix_addr_t;

	// RGB332 colour
	typedef logic [`COLOR_W-1:0] color_t;

	// APB side
	typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [`WORD_W-1:0] word_t;

	// Iterator FSM
	typedef enum logic [1:0] {
		ITER_IDLE,
		ITER_CALC,
		ITER_DONE
	} iter_state_t;

	// Raster walker FSM
	typedef enum logic [1:0] {
		WALK_IDLE,
		WALK_ISSUE,
		WALK_WAIT,
		WALK_EMIT
	} walk_state_t;

endpackage

`default_nettype wire

// File: design/mandel_top.sv
`timescale 1ns/1ps
`default_nettype none

module mandel_top (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    psel,
	input  wire                    penable,
	input  wire                    pwrite,
	input  mandel_pkg::apb_addr_t  paddr,
	input  mandel_pkg::word_t      pwdata,
	output mandel_pkg::word_t      prdata,
	output logic                   pready,
	output logic                   pslverr,
	output logic                   pix_valid,
	output mandel_pkg::pix_addr_t  pix_addr,
	output mandel_pkg::iter_t      pix_iter,
	output mandel_pkg::color_t     pix_color
);

	// Register block to walker
	logic               frame_start;
	logic               frame_done;
	mandel_pkg::fixed_t cr_start;
	mandel_pkg::fixed_t ci_start;
	mandel_pkg::fixed_t dx;
	mandel_pkg::fixed_t dy;
	mandel_pkg::coord_t cols;
	mandel_pkg::coord_t rows;
	mandel_pkg::iter_t  max_iter;

	// Walker to iterator and palette
	logic               calc_start;
	logic               calc_done;
	mandel_pkg::fixed_t cr;
	mandel_pkg::fixed_t ci;
	mandel_pkg::iter_t  iter;
	mandel_pkg::color_t color;

	apb_regs i_regs (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr),
		.frame_done(frame_done), .frame_start(frame_start),
		.cr_start(cr_start), .ci_start(ci_start), .dx(dx), .dy(dy),
		.cols(cols), .rows(rows), .max_iter(max_iter)
	);

	pixel_walker i_walker (
		.clk(clk), .rst(rst), .frame_start(frame_start),
		.cr_start(cr_start), .ci_start(ci_start), .dx(dx), .dy(dy),
		.cols(cols), .rows(rows),
		.calc_done(calc_done), .iter(iter), .color(color),
		.calc_start(calc_start), .cr(cr), .ci(ci), .frame_done(frame_done),
		.pix_valid(pix_valid), .pix_addr(pix_addr),
		.pix_iter(pix_iter), .pix_color(pix_color)
	);

	mandel_iterator i_iter (
		.clk(clk), .rst(rst), .calc_start(calc_start),
		.cr(cr), .ci(ci), .max_iter(max_iter),
		.calc_done(calc_done), .iter(iter)
	);

	// Colour settles in the same cycle as the iterator result
	palette_lut i_palette (
		.iter(iter), .max_iter(max_iter), .color(color)
	);

endmodule

`default_nettype wire

// File: design/palette_lut.sv
`timescale 1ns/1ps
`include "mandel_consts.svh"
`default_nettype none

module palette_lut (
	input  mandel_pkg::iter_t   iter,
	input  mandel_pkg::iter_t   max_iter,
	output mandel_pkg::color_t  color
);

	// Priority table, highest count first
	always_comb begin
		if (iter >= max_iter)
			color = 8'h00;  // Inside the set, black
		else if (iter >= `PAL_T2)
			color = 8'h64;
		else if (iter >= `PAL_T3)
			color = 8'hA9;
		else if (iter >= `PAL_T4)
			color = 8'h65;
		else if (iter >= `PAL_T5)
			color = 8'h25;
		else if (iter >= `PAL_T6)
			color = 8'h6A;
		// Fast escapes all share one shade
		else
			color = 8'h92;
	end

endmodule

`default_nettype wire

// File: design/pixel_walker.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_walker (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    frame_start,
	input  mandel_pkg::fixed_t     cr_start,
	input  mandel_pkg::fixed_t     ci_start,
	input  mandel_pkg::fixed_t     dx,
	input  mandel_pkg::fixed_t     dy,
	input  mandel_pkg::coord_t     cols,
	input  mandel_pkg::coord_t     rows,
	input  wire                    calc_done,
	input  mandel_pkg::iter_t      iter,
	input  mandel_pkg::color_t     color,
	output logic                   calc_start,
	output mandel_pkg::fixed_t     cr,
	output mandel_pkg::fixed_t     ci,
	output logic                   frame_done,
	output logic                   pix_valid,
	output mandel_pkg::pix_addr_t  pix_addr,
	output mandel_pkg::iter_t      pix_iter,
	output mandel_pkg::color_t     pix_color
);

	mandel_pkg::walk_state_t state;
	mandel_pkg::coord_t x;
	mandel_pkg::coord_t y;
	logic last_col;
	logic last_row;

	assign last_col = (x == mandel_pkg::coord_t'(cols - 1'b1));
	assign last_row = (y == mandel_pkg::coord_t'(rows - 1'b1));

	// One point in flight, issued for a single cycle
	assign calc_start = (state == mandel_pkg::WALK_ISSUE);

	//////////////////////////////
	// Raster FSM
	//////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state      <= mandel_pkg::WALK_IDLE;
			x          <= '0;
			y          <= '0;
			pix_valid  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			pix_valid  <= 1'b0;
			frame_done <= 1'b0;
			case (state)
				mandel_pkg::WALK_IDLE: begin
					if (frame_start) begin
						x <= '0;
						y <= '0;
						// Empty frame finishes at once
						if (cols == '0 || rows == '0)
							frame_done <= 1'b1;
						else
							state <= mandel_pkg::WALK_ISSUE;
					end
				end
				mandel_pkg::WALK_ISSUE: state <= mandel_pkg::WALK_WAIT;
				mandel_pkg::WALK_WAIT: begin
					if (calc_done) begin
						pix_valid <= 1'b1;
						state     <= mandel_pkg::WALK_EMIT;
					end
				end
				mandel_pkg::WALK_EMIT: begin
					// Strobe is out this cycle, move to the next pixel
					if (!last_col) begin
						x     <= x + 1'b1;
						state <= mandel_pkg::WALK_ISSUE;
					end else if (!last_row) begin
						x     <= '0;
						y     <= y + 1'b1;
						state <= mandel_pkg::WALK_ISSUE;
					end else begin
						frame_done <= 1'b1;
						state      <= mandel_pkg::WALK_IDLE;
					end
				end
				default: state <= mandel_pkg::WALK_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Point and pixel payload
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (state == mandel_pkg::WALK_IDLE && frame_start) begin
			cr       <= cr_start;
			ci       <= ci_start;
			pix_addr <= '0;
		end
		// Iterator result and its colour are valid only with calc_done
		if (state == mandel_pkg::WALK_WAIT && calc_done) begin
			pix_iter  <= iter;
			pix_color <= color;
		end
		if (state == mandel_pkg::WALK_EMIT) begin
			// Running y*cols + x
			pix_addr <= pix_addr + 1'b1;
			if (last_col) begin
				cr <= cr_start;
				ci <= ci - dy;  // Rows go down the imaginary axis
			end else begin
				cr <= cr + dx;
			end
		end
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+design
design/mandel_pkg.sv
design/mandel_iterator.sv
design/palette_lut.sv
design/pixel_walker.sv
design/apb_regs.sv
design/mandel_top.sv
verif/mandel_assert.sv
verif/mandel_tb.sv

// File: verif/mandel_assert.sv
`timescale 1ns/1ps
`include "mandel_consts.svh"
`default_nettype none

module mandel_assert (
	input wire                    clk,
	input wire                    rst,
	input wire                    pix_valid,
	input mandel_pkg::pix_addr_t  pix_addr,
	input wire                    pready,
	input wire                    busy,
	input mandel_pkg::coord_t     cols,
	input mandel_pkg::coord_t     rows
);

	// Frame area, wide enough for the full product
	logic [2*`COORD_W-1:0] area;

	// Number of failed assertions so far
	int n_failed = 0;

	assign area = cols * rows;

	// Pixels only inside a running frame
	a_pix_busy: assert property (@(posedge clk) disable iff (rst) pix_valid |-> busy)
		else begin
			$error("pixel strobe outside a busy frame");
			n_failed++;
		end

	// Address stays inside the frame
	a_pix_range: assert property (@(posedge clk) disable iff (rst)
		pix_valid |-> (pix_addr < area))
		else begin
			$error("pixel address beyond the frame");
			n_failed++;
		end

	// Zero wait state slave
	a_pready: assert property (@(posedge clk) disable iff (rst) pready)
		else begin
			$error("pready dropped");
			n_failed++;
		end

	// One point in flight, strobes are spaced
	a_pix_gap: assert property (@(posedge clk) disable iff (rst) pix_valid |=> !pix_valid)
		else begin
			$error("back to back pixel strobes");
			n_failed++;
		end

endmodule

// Attached to every top level instance
bind mandel_top mandel_assert i_assert (
	.clk(clk),
	.rst(rst),
	.pix_valid(pix_valid),
	.pix_addr(pix_addr),
	.pready(pready),
	.busy(i_regs.busy),
	.cols(cols),
	.rows(rows)
);

`default_nettype wire

// File: verif/mandel_tb.sv
`timescale 1ns/1ps
`include "mandel_consts.svh"
`default_nettype none

module mandel_tb;

	logic                  clk;
	logic                  rst;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	mandel_pkg::apb_addr_t paddr;
	mandel_pkg::word_t     pwdata;
	mandel_pkg::word_t     prdata;
	logic                  pready;
	logic                  pslverr;
	logic                  pix_valid;
	mandel_pkg::pix_addr_t pix_addr;
	mandel_pkg::iter_t     pix_iter;
	mandel_pkg::color_t    pix_color;

	// Stimulus and expected results
	logic [31:0] tests_mem [0:255];
	int value_errors;
	int other_errors;
	int cycle_count;
	int cycle_limit;

	// Pixels seen on the stream
	mandel_pkg::pix_addr_t got_addr[$];
	mandel_pkg::iter_t     got_iter[$];
	mandel_pkg::color_t    got_color[$];

	int n_tests;
	int p;
	int n_pix;
	int k;
	logic err;
	mandel_pkg::word_t rd;
	mandel_pkg::word_t rd2;
	mandel_pkg::word_t sum_cycles;
	mandel_pkg::word_t cols_w;
	mandel_pkg::word_t rows_w;

	mandel_top i_dut (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr),
		.pix_valid(pix_valid), .pix_addr(pix_addr),
		.pix_iter(pix_iter), .pix_color(pix_color)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////
	// Watchdog and pixel capture
	//////////////////////////////
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (!rst && pix_valid) begin
			got_addr.push_back(pix_addr);
			got_iter.push_back(pix_iter);
			got_color.push_back(pix_color);
		end
		if (cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles, a frame or status never finished",
				cycle_count);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////
	// Compare tasks
	//////////////////////////////
	task automatic check_word(input string name, input mandel_pkg::word_t got,
		input mandel_pkg::word_t exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_iter(input string name, input mandel_pkg::iter_t got,
		input mandel_pkg::iter_t exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_color(input string name, input mandel_pkg::color_t got,
		input mandel_pkg::color_t exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_addr(input string name, input mandel_pkg::pix_addr_t got,
		input mandel_pkg::pix_addr_t exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			value_errors++;
		end
	endtask

	//////////////////////////////
	// APB master
	//////////////////////////////
	task automatic idle_gap();
		int n;
		n = $urandom % 3;
		repeat (n) @(posedge clk);
	endtask

	task automatic apb_write(input mandel_pkg::apb_addr_t addr,
		input mandel_pkg::word_t data, output logic slv_err);
		idle_gap();
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		// Access phase ends here, response is stable
		@(posedge clk);
		slv_err = pslverr;
		check_bit("pready", pready, 1'b1);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input mandel_pkg::apb_addr_t addr,
		output mandel_pkg::word_t data, output logic slv_err);
		idle_gap();
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		data    = prdata;
		slv_err = pslverr;
		check_bit("pready", pready, 1'b1);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// Write, expect OK, read back the same word
	task automatic write_readback(input string name, input mandel_pkg::apb_addr_t addr,
		input mandel_pkg::word_t data);
		logic e;
		mandel_pkg::word_t r;
		apb_write(addr, data, e);
		check_bit({name, " write pslverr"}, e, 1'b0);
		apb_read(addr, r, e);
		check_word(name, r, data);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		void'($urandom(23888));
		rst          = 1'b1;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		value_errors = 0;
		other_errors = 0;
		cycle_count  = 0;

		$readmemh("verif/mandel_tests.txt", tests_mem);
		n_tests = tests_mem[0];

		// Budget per pixel is max_iter plus issue, done and emit
		cycle_limit = 5000;
		p = 1;
		for (int t = 0; t < n_tests; t++) begin
			n_pix = tests_mem[p+4] * tests_mem[p+5];
			cycle_limit += n_pix * (tests_mem[p+6] + 4);
			p += 7 + 2 * n_pix;
		end

		repeat (3) @(posedge clk);
		rst <= 1'b0;

		// Reset state
		apb_read(`REG_STATUS, rd, err);
		check_word("STATUS after reset", rd, 32'h0);
		apb_read(`REG_MAX_ITER, rd, err);
		check_word("MAX_ITER after reset", rd, `ITER_MAX_RESET);

		// Unmapped addresses
		apb_read(8'h24, rd, err);
		check_bit("pslverr read 0x24", err, 1'b1);
		apb_write(8'h40, 32'h1, err);
		check_bit("pslverr write 0x40", err, 1'b1);

		p = 1;
		for (int t = 0; t < n_tests; t++) begin
			cols_w = tests_mem[p+4];
			rows_w = tests_mem[p+5];
			n_pix  = cols_w * rows_w;

			write_readback("CR_START", `REG_CR_START, tests_mem[p]);
			write_readback("CI_START", `REG_CI_START, tests_mem[p+1]);
			write_readback("DX", `REG_DX, tests_mem[p+2]);
			write_readback("DY", `REG_DY, tests_mem[p+3]);
			write_readback("SIZE", `REG_SIZE, {6'b0, rows_w[9:0], 6'b0, cols_w[9:0]});
			write_readback("MAX_ITER", `REG_MAX_ITER, tests_mem[p+6]);

			got_addr.delete();
			got_iter.delete();
			got_color.delete();
			apb_write(`REG_CTRL, 32'h1, err);
			check_bit("CTRL start pslverr", err, 1'b0);

			// Timer restarted by this start
			apb_read(`REG_CYCLES, rd, err);
			if (rd > 16) begin
				$display("CYCLES did not restart at frame start, read %0d", rd);
				other_errors++;
			end
			apb_read(`REG_STATUS, rd, err);
			check_word("STATUS during frame", rd, 32'h1);

			// Config is locked while busy
			apb_write(`REG_DX, 32'h0012345, err);
			check_bit("pslverr DX write busy", err, 1'b1);
			apb_read(`REG_DX, rd, err);
			check_word("DX after busy write", rd, tests_mem[p+2]);
			apb_write(`REG_CTRL, 32'h1, err);
			check_bit("pslverr CTRL write busy", err, 1'b0);

			do begin
				apb_read(`REG_STATUS, rd, err);
			end while (!rd[1]);
			check_word("STATUS after frame", rd, 32'h2);

			// Room for any stray pixels to show up
			repeat (20) @(posedge clk);
			if (got_iter.size() != n_pix) begin
				$display("Frame %0d gave %0d pixels instead of %0d",
					t, got_iter.size(), n_pix);
				other_errors++;
			end

			sum_cycles = 0;
			for (k = 0; k < n_pix && k < got_iter.size(); k++) begin
				check_addr("pix_addr", got_addr[k], mandel_pkg::pix_addr_t'(k));
				check_iter("pix_iter", got_iter[k], tests_mem[p+7+2*k]);
				check_color("pix_color", got_color[k], tests_mem[p+8+2*k]);
				sum_cycles += tests_mem[p+7+2*k] + 2;
			end

			// Timer holds after the frame
			apb_read(`REG_CYCLES, rd, err);
			apb_read(`REG_CYCLES, rd2, err);
			check_word("CYCLES second read", rd2, rd);
			if (rd < sum_cycles) begin
				$display("CYCLES %0d is below the iteration total %0d", rd, sum_cycles);
				other_errors++;
			end

			p += 7 + 2 * n_pix;
		end

		$display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
			value_errors, other_errors, i_dut.i_assert.n_failed);
		if (value_errors == 0 && other_errors == 0 && i_dut.i_assert.n_failed == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/mandel_tests.txt
// Number of frames, then per frame: cr_start ci_start dx dy cols rows max_iter (hex)
// followed by cols*rows lines in raster order: expected iter, expected colour
2
// Frame 0, cr -2..2 step 1, ci 1 then 0, limit 20
FF000000 00800000 00800000 00800000 5 2 14
// Row ci = 1
1 92
3 92
14 00
2 92
1 92
// Row ci = 0
14 00
14 00
14 00
3 92
2 92
// Frame 1, cr -1..1 step 1, ci 0 then -1, limit 8
FF800000 00000000 00800000 00800000 3 2 8
// Row ci = 0
8 00
8 00
3 92
// Row ci = -1
3 92
8 00
2 92
